// ==== src.f ====
+incdir+include
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/issue_queue_if.sv
verilog/issue_queue.sv
verilog/inst_decoder.sv
verilog/reg_file.sv
verilog/issue_select.sv
verilog/decode_stage.sv
sim/tb_decode_stage.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_decode_stage
FILELIST  := src.f
LOG       := sim.log
BIN       := obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Errors found" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// ==== sim/tb_decode_stage.sv ====
`timescale 1ns/1ps
`include "decode_settings.svh"

module tb_decode_stage;

    localparam int CLK_PERIOD = 40;
    // tests run for about a hundred cycles
    localparam int MAX_CYCLES = 500;

    logic                        clk;
    logic                        rst;
    logic                        fetch_valid_i;
    isa_pkg::inst_t [1:0]        fetch_inst_i;
    logic [`DS_XLEN-1:0]         fetch_pc_i;
    logic                        stall_i;
    logic                        flush_i;
    pipe_pkg::rf_write_t [1:0]   ex_fwd_i;
    pipe_pkg::rf_write_t [1:0]   mem_fwd_i;
    pipe_pkg::rf_write_t [1:0]   wb_fwd_i;
    logic                        queue_full_o;
    logic [1:0]                  issue_valid_o;
    pipe_pkg::issue_slot_t [1:0] issue_o;

    // architectural state as the array should hold it
    logic [`DS_XLEN-1:0] shadow [`DS_NUM_REGS];
    int                  errors;
    int                  checks;
    integer              seed;

    decode_stage i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(MAX_CYCLES * CLK_PERIOD);
        $display("timeout: tests still running after %0d cycles", MAX_CYCLES);
        $display("Errors found");
        $finish;
    end

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    function automatic isa_pkg::inst_t encode_r(input isa_pkg::funct_e fn, input int rd,
                                                input int rs, input int rt);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'h00, fn};
    endfunction

    function automatic isa_pkg::inst_t encode_i(input isa_pkg::opcode_e op, input int rt,
                                                input int rs, input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic pipe_pkg::rf_write_t result_bus(input int addr, input logic [31:0] data);
        pipe_pkg::rf_write_t w;
        w.we    = 1'b1;
        w.waddr = 5'(addr);
        w.wdata = data;
        return w;
    endfunction

    // expected slot from the subset's encoding rules
    function automatic pipe_pkg::issue_slot_t model_slot(input logic [31:0] pc,
                                                         input isa_pkg::inst_t inst);
        pipe_pkg::issue_slot_t s;
        logic [4:0]            dest;
        logic                  bad;
        s.pc     = pc;
        s.inst   = inst;
        s.alu_op = isa_pkg::ALU_ADD;
        s.src_a  = shadow[inst[25:21]];
        s.src_b  = {16'h0000, inst[15:0]};
        dest     = inst[20:16];
        bad      = 1'b0;
        case (inst[31:26])
            isa_pkg::OP_SPECIAL: begin
                s.src_b = shadow[inst[20:16]];
                dest    = inst[15:11];
                case (inst[5:0])
                    isa_pkg::FN_ADDU: s.alu_op = isa_pkg::ALU_ADD;
                    isa_pkg::FN_SUBU: s.alu_op = isa_pkg::ALU_SUB;
                    isa_pkg::FN_AND:  s.alu_op = isa_pkg::ALU_AND;
                    isa_pkg::FN_OR:   s.alu_op = isa_pkg::ALU_OR;
                    isa_pkg::FN_XOR:  s.alu_op = isa_pkg::ALU_XOR;
                    isa_pkg::FN_SLT:  s.alu_op = isa_pkg::ALU_SLT;
                    default:          bad = 1'b1;
                endcase
            end
            isa_pkg::OP_ADDIU: s.src_b = {{16{inst[15]}}, inst[15:0]};
            isa_pkg::OP_ANDI:  s.alu_op = isa_pkg::ALU_AND;
            isa_pkg::OP_ORI:   s.alu_op = isa_pkg::ALU_OR;
            isa_pkg::OP_XORI:  s.alu_op = isa_pkg::ALU_XOR;
            isa_pkg::OP_LUI: begin
                s.alu_op = isa_pkg::ALU_OR;
                s.src_a  = '0;
                s.src_b  = {inst[15:0], 16'h0000};
            end
            default: begin
                // unknown opcode reads plain register operands and has no destination
                s.src_b = shadow[inst[20:16]];
                dest    = '0;
                bad     = 1'b1;
            end
        endcase
        s.rf_waddr = dest;
        s.rf_we    = !bad && dest != '0;
        return s;
    endfunction

    task automatic check_bit(input string name, input logic [1:0] exp, input logic [1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error at %0t: %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    task automatic compare_field(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error at %0t: %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_slot(input string name, input pipe_pkg::issue_slot_t exp,
                              input pipe_pkg::issue_slot_t act);
        compare_field({name, ".pc"}, exp.pc, act.pc);
        compare_field({name, ".inst"}, exp.inst, act.inst);
        compare_field({name, ".alu_op"}, 32'(exp.alu_op), 32'(act.alu_op));
        compare_field({name, ".src_a"}, exp.src_a, act.src_a);
        compare_field({name, ".src_b"}, exp.src_b, act.src_b);
        compare_field({name, ".rf_we"}, 32'(exp.rf_we), 32'(act.rf_we));
        compare_field({name, ".rf_waddr"}, 32'(exp.rf_waddr), 32'(act.rf_waddr));
    endtask

    task automatic clear_buses();
        ex_fwd_i  = '0;
        mem_fwd_i = '0;
        wb_fwd_i  = '0;
    endtask

    task automatic push_pair(input logic [31:0] pc, input isa_pkg::inst_t i0,
                             input isa_pkg::inst_t i1);
        fetch_valid_i   = 1'b1;
        fetch_inst_i[0] = i0;
        fetch_inst_i[1] = i1;
        fetch_pc_i      = pc;
        tick();
        fetch_valid_i   = 1'b0;
    endtask

    // one pair through the stage in one or two issue cycles
    task automatic run_pair(input logic [31:0] pc, input isa_pkg::inst_t i0,
                            input isa_pkg::inst_t i1, input logic dual);
        push_pair(pc, i0, i1);
        tick();
        check_bit("issue_valid_o", dual ? 2'b11 : 2'b01, issue_valid_o);
        check_slot("issue_o[0]", model_slot(pc, i0), issue_o[0]);
        if (dual) begin
            check_slot("issue_o[1]", model_slot(pc + 4, i1), issue_o[1]);
        end else begin
            tick();
            check_bit("issue_valid_o", 2'b01, issue_valid_o);
            check_slot("issue_o[0]", model_slot(pc + 4, i1), issue_o[0]);
        end
        tick();
        check_bit("issue_valid_o", 2'b00, issue_valid_o);
    endtask

    task automatic preload_regs();
        for (int r = 1; r < `DS_NUM_REGS; r++) begin
            shadow[r]         = $random(seed);
            wb_fwd_i[r[0]]    = result_bus(r, shadow[r]);
            tick();
            wb_fwd_i          = '0;
        end
    endtask

    task automatic dual_issue_test();
        run_pair(32'h0000_1000, encode_r(isa_pkg::FN_ADDU, 5, 1, 2),
                 encode_i(isa_pkg::OP_ORI, 6, 3, 16'h8001), 1'b1);
        run_pair(32'h0000_1008, encode_r(isa_pkg::FN_SUBU, 7, 4, 1),
                 encode_r(isa_pkg::FN_SLT, 8, 2, 3), 1'b1);
        run_pair(32'h0000_1010, encode_i(isa_pkg::OP_LUI, 9, 5, 16'h1234),
                 encode_i(isa_pkg::OP_ADDIU, 10, 4, 16'hfffd), 1'b1);
        run_pair(32'h0000_1018, encode_r(isa_pkg::FN_AND, 0, 1, 3),
                 encode_i(isa_pkg::OP_XORI, 12, 2, 16'hf0f0), 1'b1);
        run_pair(32'h0000_1020, encode_i(isa_pkg::OP_ANDI, 13, 6, 16'h00ff),
                 {6'h00, 5'd1, 5'd2, 5'd3, 5'd0, 6'h3f}, 1'b0);
        run_pair(32'h0000_1028, {6'h3f, 26'h0}, encode_r(isa_pkg::FN_OR, 14, 7, 8), 1'b0);
    endtask

    task automatic dependency_test();
        run_pair(32'h0000_1100, encode_r(isa_pkg::FN_ADDU, 14, 1, 2),
                 encode_i(isa_pkg::OP_ADDIU, 15, 14, 16'h0005), 1'b0);
        run_pair(32'h0000_1108, encode_i(isa_pkg::OP_ORI, 16, 3, 16'h0007),
                 encode_r(isa_pkg::FN_SUBU, 17, 4, 16), 1'b0);
        // same destination and no read between them
        run_pair(32'h0000_1110, encode_i(isa_pkg::OP_ADDIU, 18, 1, 16'h0001),
                 encode_i(isa_pkg::OP_ADDIU, 18, 2, 16'h0002), 1'b1);
        // lui has no rs read
        run_pair(32'h0000_1118, encode_r(isa_pkg::FN_OR, 19, 1, 2),
                 encode_i(isa_pkg::OP_LUI, 21, 19, 16'h00aa), 1'b1);
    endtask

    task automatic forwarding_test();
        logic [31:0]           ex1;
        logic [31:0]           wb1;
        pipe_pkg::issue_slot_t exp;
        isa_pkg::inst_t        i0;
        isa_pkg::inst_t        i1;
        ex1 = $random(seed);
        wb1 = $random(seed);
        i0  = encode_r(isa_pkg::FN_ADDU, 21, 20, 0);
        i1  = encode_i(isa_pkg::OP_ORI, 22, 0, 16'h0055);
        push_pair(32'h0000_2000, i0, i1);
        ex_fwd_i[1]  = result_bus(20, ex1);
        ex_fwd_i[0]  = result_bus(20, $random(seed));
        mem_fwd_i[1] = result_bus(20, $random(seed));
        mem_fwd_i[0] = result_bus(20, $random(seed));
        wb_fwd_i[1]  = result_bus(20, wb1);
        wb_fwd_i[0]  = result_bus(20, $random(seed));
        tick();
        clear_buses();
        shadow[20] = wb1;
        exp        = model_slot(32'h0000_2000, i0);
        exp.src_a  = ex1;
        check_bit("issue_valid_o", 2'b11, issue_valid_o);
        check_slot("issue_o[0]", exp, issue_o[0]);
        check_slot("issue_o[1]", model_slot(32'h0000_2004, i1), issue_o[1]);
        // wb alone plus a mem result aimed at r0
        i0 = encode_r(isa_pkg::FN_ADDU, 24, 23, 20);
        i1 = encode_i(isa_pkg::OP_ORI, 25, 0, 16'h0007);
        push_pair(32'h0000_2008, i0, i1);
        shadow[23]   = $random(seed);
        wb_fwd_i[0]  = result_bus(23, shadow[23]);
        mem_fwd_i[0] = result_bus(0, $random(seed));
        tick();
        clear_buses();
        check_bit("issue_valid_o", 2'b11, issue_valid_o);
        check_slot("issue_o[0]", model_slot(32'h0000_2008, i0), issue_o[0]);
        check_slot("issue_o[1]", model_slot(32'h0000_200c, i1), issue_o[1]);
        tick();
        check_bit("issue_valid_o", 2'b00, issue_valid_o);
    endtask

    task automatic stall_flush_test();
        isa_pkg::inst_t i0;
        isa_pkg::inst_t i1;
        i0 = encode_r(isa_pkg::FN_XOR, 26, 1, 2);
        i1 = encode_i(isa_pkg::OP_ORI, 27, 3, 16'h0f0f);
        push_pair(32'h0000_3000, i0, i1);
        tick();
        stall_i = 1'b1;
        push_pair(32'h0000_3008, encode_r(isa_pkg::FN_AND, 28, 4, 5),
                  encode_r(isa_pkg::FN_OR, 29, 6, 7));
        repeat (2) begin
            check_bit("issue_valid_o", 2'b11, issue_valid_o);
            check_slot("issue_o[0]", model_slot(32'h0000_3000, i0), issue_o[0]);
            check_slot("issue_o[1]", model_slot(32'h0000_3004, i1), issue_o[1]);
            tick();
        end
        flush_i = 1'b1;
        stall_i = 1'b0;
        tick();
        flush_i = 1'b0;
        repeat (3) begin
            check_bit("issue_valid_o", 2'b00, issue_valid_o);
            tick();
        end
    endtask

    task automatic queue_full_test();
        isa_pkg::inst_t pairs [4][2];
        stall_i = 1'b1;
        for (int k = 0; k < 4; k++) begin
            check_bit("queue_full_o", 2'b00, 2'(queue_full_o));
            pairs[k][0] = encode_r(isa_pkg::FN_ADDU, 8 + k, 1, 2);
            pairs[k][1] = encode_i(isa_pkg::OP_XORI, 12 + k, 3, 16'($random(seed)));
            push_pair(32'h0000_4000 + 8 * k, pairs[k][0], pairs[k][1]);
        end
        check_bit("queue_full_o", 2'b01, 2'(queue_full_o));
        stall_i = 1'b0;
        for (int k = 0; k < 4; k++) begin
            tick();
            check_bit("issue_valid_o", 2'b11, issue_valid_o);
            check_bit("queue_full_o", 2'b00, 2'(queue_full_o));
            check_slot("issue_o[0]", model_slot(32'h0000_4000 + 8 * k, pairs[k][0]), issue_o[0]);
            check_slot("issue_o[1]", model_slot(32'h0000_4004 + 8 * k, pairs[k][1]), issue_o[1]);
        end
        tick();
        check_bit("issue_valid_o", 2'b00, issue_valid_o);
    endtask

    initial begin
        seed          = 32'h04db_bb05;
        errors        = 0;
        checks        = 0;
        rst           = 1'b1;
        fetch_valid_i = 1'b0;
        fetch_inst_i  = '0;
        fetch_pc_i    = '0;
        stall_i       = 1'b0;
        flush_i       = 1'b0;
        clear_buses();
        for (int r = 0; r < `DS_NUM_REGS; r++) begin
            shadow[r] = '0;
        end
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        check_bit("issue_valid_o", 2'b00, issue_valid_o);
        check_bit("queue_full_o", 2'b00, 2'(queue_full_o));
        preload_regs();
        dual_issue_test();
        dependency_test();
        forwarding_test();
        stall_flush_test();
        queue_full_test();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== verilog/decode_stage.sv ====
`timescale 1ns/1ps
`include "decode_settings.svh"

module decode_stage (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             fetch_valid_i,
    input  isa_pkg::inst_t [1:0]             fetch_inst_i,
    input  logic [`DS_XLEN-1:0]              fetch_pc_i,
    input  logic                             stall_i,
    input  logic                             flush_i,
    input  pipe_pkg::rf_write_t [1:0]        ex_fwd_i,
    input  pipe_pkg::rf_write_t [1:0]        mem_fwd_i,
    input  pipe_pkg::rf_write_t [1:0]        wb_fwd_i,
    output logic                             queue_full_o,
    output logic [1:0]                       issue_valid_o,
    output pipe_pkg::issue_slot_t [1:0]      issue_o
);

    issue_queue_if q_if ();

    pipe_pkg::decoded_t [1:0]        dec;
    logic [3:0][`DS_REG_AW-1:0]      raddr;
    logic [3:0][`DS_XLEN-1:0]        rdata;

    issue_queue i_queue (
        .clk        (clk),
        .rst        (rst),
        .flush_i    (flush_i),
        .wr_valid_i (fetch_valid_i),
        .wr_inst_i  (fetch_inst_i),
        .wr_pc_i    (fetch_pc_i),
        .full_o     (queue_full_o),
        .q          (q_if.queue)
    );

    for (genvar k = 0; k < 2; k++) begin : g_dec
        inst_decoder i_dec (
            .inst_i (q_if.head_inst[k]),
            .dec_o  (dec[k])
        );
        assign raddr[2*k]   = q_if.head_inst[k][isa_pkg::RS_MSB:isa_pkg::RS_LSB];
        assign raddr[2*k+1] = q_if.head_inst[k][isa_pkg::RT_MSB:isa_pkg::RT_LSB];
    end

    // wb results double as the write port
    reg_file i_rf (
        .clk     (clk),
        .rst     (rst),
        .wb_i    (wb_fwd_i),
        .ex_i    (ex_fwd_i),
        .mem_i   (mem_fwd_i),
        .raddr_i (raddr),
        .rdata_o (rdata)
    );

    issue_select i_select (
        .clk           (clk),
        .rst           (rst),
        .stall_i       (stall_i),
        .flush_i       (flush_i),
        .q             (q_if.issue),
        .dec_i         (dec),
        .rdata_i       (rdata),
        .issue_valid_o (issue_valid_o),
        .issue_o       (issue_o)
    );

endmodule

// ==== verilog/issue_select.sv ====
`timescale 1ns/1ps
`include "decode_settings.svh"

module issue_select (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             stall_i,
    input  logic                             flush_i,
    issue_queue_if.issue                     q,
    input  pipe_pkg::decoded_t [1:0]         dec_i,
    input  logic [3:0][`DS_XLEN-1:0]         rdata_i,
    output logic [1:0]                       issue_valid_o,
    output pipe_pkg::issue_slot_t [1:0]      issue_o
);

    logic [`DS_REG_AW-1:0]        rs1;
    logic [`DS_REG_AW-1:0]        rt1;
    logic                         raw_dep;
    logic                         go0;
    logic                         go1;
    pipe_pkg::issue_slot_t [1:0]  slot_d;

    assign rs1 = q.head_inst[1][isa_pkg::RS_MSB:isa_pkg::RS_LSB];
    assign rt1 = q.head_inst[1][isa_pkg::RT_MSB:isa_pkg::RT_LSB];

    // younger reads what the older one writes
    assign raw_dep = dec_i[0].rf_we &&
                     ((dec_i[1].reads_rs && rs1 == dec_i[0].rf_waddr) ||
                      (dec_i[1].reads_rt && rt1 == dec_i[0].rf_waddr));

    assign go0 = q.head_valid[0];
    assign go1 = q.head_valid[1] && !dec_i[0].illegal && !dec_i[1].illegal && !raw_dep;

    assign q.pop_count = (stall_i || flush_i) ? 2'd0 :
                         go1                  ? 2'd2 :
                         go0                  ? 2'd1 : 2'd0;

    // rdata_i is rs0, rt0, rs1, rt1
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            slot_d[s].pc       = q.head_pc[s];
            slot_d[s].inst     = q.head_inst[s];
            slot_d[s].alu_op   = dec_i[s].alu_op;
            slot_d[s].src_a    = (q.head_inst[s][isa_pkg::OP_MSB:isa_pkg::OP_LSB] ==
                                  isa_pkg::OP_LUI) ? '0 : rdata_i[2*s];
            slot_d[s].src_b    = dec_i[s].use_imm ? dec_i[s].imm_value : rdata_i[2*s+1];
            slot_d[s].rf_we    = dec_i[s].rf_we;
            slot_d[s].rf_waddr = dec_i[s].rf_waddr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            issue_valid_o <= 2'b00;
        end else if (!stall_i) begin
            issue_valid_o <= {go1, go0};
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            issue_o <= slot_d;
        end
    end

endmodule

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ps
`include "decode_settings.svh"

module reg_file (
    input  logic                             clk,
    input  logic                             rst,
    input  pipe_pkg::rf_write_t [1:0]        wb_i,
    input  pipe_pkg::rf_write_t [1:0]        ex_i,
    input  pipe_pkg::rf_write_t [1:0]        mem_i,
    input  logic [3:0][`DS_REG_AW-1:0]       raddr_i,
    output logic [3:0][`DS_XLEN-1:0]         rdata_o
);

    logic [`DS_NUM_REGS-1:0][`DS_XLEN-1:0] regs;

    // slot 1 is written last so it wins a shared address
    always_ff @(posedge clk) begin
        if (rst) begin
            regs <= '0;
        end else begin
            for (int s = 0; s < 2; s++) begin
                if (wb_i[s].we && wb_i[s].waddr != '0) begin
                    regs[wb_i[s].waddr] <= wb_i[s].wdata;
                end
            end
        end
    end

    // lowest priority first, each later match overrides
    always_comb begin
        for (int p = 0; p < 4; p++) begin
            rdata_o[p] = regs[raddr_i[p]];
            for (int s = 0; s < 2; s++) begin
                if (wb_i[s].we && wb_i[s].waddr == raddr_i[p]) begin
                    rdata_o[p] = wb_i[s].wdata;
                end
            end
            for (int s = 0; s < 2; s++) begin
                if (mem_i[s].we && mem_i[s].waddr == raddr_i[p]) begin
                    rdata_o[p] = mem_i[s].wdata;
                end
            end
            for (int s = 0; s < 2; s++) begin
                if (ex_i[s].we && ex_i[s].waddr == raddr_i[p]) begin
                    rdata_o[p] = ex_i[s].wdata;
                end
            end
            if (raddr_i[p] == '0) begin
                rdata_o[p] = '0;
            end
        end
    end

endmodule

// ==== verilog/inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder (
    input  isa_pkg::inst_t      inst_i,
    output pipe_pkg::decoded_t  dec_o
);

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [15:0] imm;

    assign opcode = inst_i[isa_pkg::OP_MSB:isa_pkg::OP_LSB];
    assign funct  = inst_i[isa_pkg::FN_MSB:isa_pkg::FN_LSB];
    assign rt     = inst_i[isa_pkg::RT_MSB:isa_pkg::RT_LSB];
    assign rd     = inst_i[isa_pkg::RD_MSB:isa_pkg::RD_LSB];
    assign imm    = inst_i[isa_pkg::IMM_MSB:isa_pkg::IMM_LSB];

    always_comb begin
        dec_o        = '0;
        dec_o.alu_op = isa_pkg::ALU_ADD;
        case (opcode)
            isa_pkg::OP_SPECIAL: begin
                dec_o.reads_rs = 1'b1;
                dec_o.reads_rt = 1'b1;
                dec_o.rf_we    = 1'b1;
                dec_o.rf_waddr = rd;
                case (funct)
                    isa_pkg::FN_ADDU: dec_o.alu_op = isa_pkg::ALU_ADD;
                    isa_pkg::FN_SUBU: dec_o.alu_op = isa_pkg::ALU_SUB;
                    isa_pkg::FN_AND:  dec_o.alu_op = isa_pkg::ALU_AND;
                    isa_pkg::FN_OR:   dec_o.alu_op = isa_pkg::ALU_OR;
                    isa_pkg::FN_XOR:  dec_o.alu_op = isa_pkg::ALU_XOR;
                    isa_pkg::FN_SLT:  dec_o.alu_op = isa_pkg::ALU_SLT;
                    default: begin
                        dec_o.reads_rs = 1'b0;
                        dec_o.reads_rt = 1'b0;
                        dec_o.rf_we    = 1'b0;
                        dec_o.illegal  = 1'b1;
                    end
                endcase
            end
            isa_pkg::OP_ADDIU, isa_pkg::OP_ANDI, isa_pkg::OP_ORI, isa_pkg::OP_XORI: begin
                dec_o.reads_rs  = 1'b1;
                dec_o.use_imm   = 1'b1;
                dec_o.rf_we     = 1'b1;
                dec_o.rf_waddr  = rt;
                // logical ops zero-extend, addiu sign-extends
                dec_o.imm_value = {16'b0, imm};
                case (opcode)
                    isa_pkg::OP_ANDI: dec_o.alu_op = isa_pkg::ALU_AND;
                    isa_pkg::OP_ORI:  dec_o.alu_op = isa_pkg::ALU_OR;
                    isa_pkg::OP_XORI: dec_o.alu_op = isa_pkg::ALU_XOR;
                    default: begin
                        dec_o.alu_op    = isa_pkg::ALU_ADD;
                        dec_o.imm_value = {{16{imm[15]}}, imm};
                    end
                endcase
            end
            isa_pkg::OP_LUI: begin
                // or with a zero source
                dec_o.alu_op    = isa_pkg::ALU_OR;
                dec_o.use_imm   = 1'b1;
                dec_o.imm_value = {imm, 16'b0};
                dec_o.rf_we     = 1'b1;
                dec_o.rf_waddr  = rt;
            end
            default: begin
                dec_o.illegal = 1'b1;
            end
        endcase
        if (dec_o.rf_waddr == '0) begin
            dec_o.rf_we = 1'b0;
        end
    end

endmodule

// ==== verilog/issue_queue.sv ====
`timescale 1ns/1ps
`include "decode_settings.svh"

module issue_queue (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      flush_i,
    input  logic                      wr_valid_i,
    input  isa_pkg::inst_t [1:0]      wr_inst_i,
    input  logic [`DS_XLEN-1:0]       wr_pc_i,
    output logic                      full_o,
    issue_queue_if.queue              q
);

    localparam int DEPTH = `DS_QUEUE_DEPTH;
    localparam int PW    = $clog2(DEPTH);
    localparam int CW    = PW + 1;

    isa_pkg::inst_t [DEPTH-1:0]         inst_mem;
    logic [DEPTH-1:0][`DS_XLEN-1:0]     pc_mem;

    logic [PW-1:0] head;
    logic [PW-1:0] head_p1;
    logic [PW-1:0] tail;
    logic [CW-1:0] count;
    logic          wr_en;

    assign full_o  = count > CW'(DEPTH - 2);
    assign wr_en   = wr_valid_i && !full_o;
    assign head_p1 = head + PW'(1);

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (wr_en) begin
                tail <= tail + PW'(2);
            end
            head  <= head + PW'(q.pop_count);
            count <= count + (wr_en ? CW'(2) : CW'(0)) - CW'(q.pop_count);
        end
    end

    // lower word first so it is the older entry
    always_ff @(posedge clk) begin
        if (wr_en) begin
            inst_mem[tail]         <= wr_inst_i[0];
            inst_mem[tail + PW'(1)] <= wr_inst_i[1];
            pc_mem[tail]           <= wr_pc_i;
            pc_mem[tail + PW'(1)]   <= wr_pc_i + `DS_XLEN'(4);
        end
    end

    assign q.head_inst[0]  = inst_mem[head];
    assign q.head_inst[1]  = inst_mem[head_p1];
    assign q.head_pc[0]    = pc_mem[head];
    assign q.head_pc[1]    = pc_mem[head_p1];
    assign q.head_valid[0] = count != '0;
    assign q.head_valid[1] = count > CW'(1);

    a_no_write_full: assert property (
        @(posedge clk) disable iff (rst) wr_valid_i |-> !full_o
    );

    // the issue side must only take what is presented
    a_no_over_pop: assert property (
        @(posedge clk) disable iff (rst) CW'(q.pop_count) <= count
    );

endmodule

// ==== verilog/issue_queue_if.sv ====
`timescale 1ns/1ps
`include "decode_settings.svh"

interface issue_queue_if;

    // two oldest entries, index 0 is older
    logic [1:0][`DS_XLEN-1:0] head_inst;
    logic [1:0][`DS_XLEN-1:0] head_pc;
    logic [1:0]               head_valid;

    // entries consumed at the next edge, 0 to 2
    logic [1:0]               pop_count;

    modport queue (output head_inst, head_pc, head_valid, input pop_count);

    modport issue (input head_inst, head_pc, head_valid, output pop_count);

endinterface

// ==== verilog/pipe_pkg.sv ====
`include "decode_settings.svh"

package pipe_pkg;

    // one decoded instruction
    typedef struct packed {
        isa_pkg::alu_op_e      alu_op;
        logic                  reads_rs;
        logic                  reads_rt;
        logic                  use_imm;
        logic [`DS_XLEN-1:0]   imm_value;
        logic                  rf_we;
        logic [`DS_REG_AW-1:0] rf_waddr;
        logic                  illegal;
    } decoded_t;

    // result bus from a later stage
    typedef struct packed {
        logic                  we;
        logic [`DS_REG_AW-1:0] waddr;
        logic [`DS_XLEN-1:0]   wdata;
    } rf_write_t;

    // what one issue slot hands to EX
    typedef struct packed {
        logic [`DS_XLEN-1:0]   pc;
        isa_pkg::inst_t        inst;
        isa_pkg::alu_op_e      alu_op;
        logic [`DS_XLEN-1:0]   src_a;
        logic [`DS_XLEN-1:0]   src_b;
        logic                  rf_we;
        logic [`DS_REG_AW-1:0] rf_waddr;
    } issue_slot_t;

endpackage

// ==== verilog/isa_pkg.sv ====
package isa_pkg;

    typedef logic [31:0] inst_t;

    // major opcodes of the supported subset
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f
    } opcode_e;

    // funct codes under OP_SPECIAL
    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

    // instruction word fields
    localparam int OP_MSB  = 31;
    localparam int OP_LSB  = 26;
    localparam int RS_MSB  = 25;
    localparam int RS_LSB  = 21;
    localparam int RT_MSB  = 20;
    localparam int RT_LSB  = 16;
    localparam int RD_MSB  = 15;
    localparam int RD_LSB  = 11;
    localparam int FN_MSB  = 5;
    localparam int FN_LSB  = 0;
    localparam int IMM_MSB = 15;
    localparam int IMM_LSB = 0;

endpackage

// ==== include/decode_settings.svh ====
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// instruction queue entries, a power of two
`define DS_QUEUE_DEPTH 8

// architectural registers
`define DS_NUM_REGS 32

// data and pc width
`define DS_XLEN 32

// register index width
`define DS_REG_AW 5

`endif
